//--- Makefile
VERILATOR ?= verilator
TOP       ?= mult16_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= SIMULATION PASSED

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out=$$(./$(SIM) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+include
source/mult_data_pkg.sv
source/mult_pipe_pkg.sv
source/dadda_tree.sv
source/carry_select_adder.sv
source/mult16_pipe.sv
verif/mult16_assert.sv
verif/mult16_tb.sv

//--- include/mult_consts.svh
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// factor and product widths.
`define MULT_OP_W 16
`define MULT_PROD_W 32

// bits per carry-select block.
`define MULT_CSA_BLK 4

// operand, row and product registers.
`define MULT_PIPE_DEPTH 3

`endif

//--- source/carry_select_adder.sv
`timescale 1ns/100ps
`include "mult_consts.svh"

module carry_select_adder (
    input  mult_data_pkg::row_pair_t rows,
    output mult_data_pkg::product_t  sum
);
    localparam int BLK  = `MULT_CSA_BLK;
    localparam int NBLK = `MULT_PROD_W / BLK;

    logic [NBLK-1:0] blk_cout; // top carry out is dropped.

    for (genvar k = 0; k < NBLK; k++) begin : g_blk
        logic [BLK-1:0] x;
        logic [BLK-1:0] y;
        logic [BLK:0]   res;

        assign x = rows.sum_row[k*BLK +: BLK];
        assign y = rows.carry_row[k*BLK +: BLK];

        if (k == 0) begin : g_first
            assign res = {1'b0, x} + {1'b0, y}; // no carry into bit 0.
        end else begin : g_sel
            logic [BLK:0] res_c0;
            logic [BLK:0] res_c1;

            // both results ready before the carry arrives.
            assign res_c0 = {1'b0, x} + {1'b0, y};
            assign res_c1 = {1'b0, x} + {1'b0, y} + (BLK+1)'(1);
            assign res    = blk_cout[k-1] ? res_c1 : res_c0;
        end

        assign sum[k*BLK +: BLK] = res[BLK-1:0];
        assign blk_cout[k]       = res[BLK];
    end

endmodule

//--- source/dadda_tree.sv
`timescale 1ns/100ps
`include "mult_consts.svh"

module dadda_tree (
    input  mult_data_pkg::operands_t operands,
    output mult_data_pkg::row_pair_t rows
);
    import mult_data_pkg::*;

    localparam int OP_W   = `MULT_OP_W;
    localparam int PROD_W = `MULT_PROD_W;

    // number of AND terms of weight col.
    function automatic int pp_height(int col);
        return (col < OP_W) ? col + 1 : 2 * OP_W - 1 - col;
    endfunction

    function automatic int dadda_levels();
        int d;
        int n;
        d = 2;
        n = 0;
        while (d < OP_W) begin
            n++;
            d = d * 3 / 2;
        end
        return n;
    endfunction

    // height limit after level lvl (13 9 6 4 3 2 for 16 bits).
    function automatic int dadda_target(int lvl);
        int d;
        d = 2;
        for (int k = 0; k < dadda_levels() - 1 - lvl; k++) begin
            d = d * 3 / 2;
        end
        return d;
    endfunction

    // kind 0 gives the height entering level lvl, 1 the full adders, 2 the half adders.
    function automatic int tree_info(int lvl, int col, int kind);
        int h  [PROD_W];
        int hp [PROD_W];
        int fa [PROD_W];
        int ha [PROD_W];
        int cin;
        int e;
        if (col < 0) begin
            return 0;
        end
        for (int j = 0; j < PROD_W; j++) begin
            h[j] = pp_height(j);
        end
        for (int l = 0; l <= lvl; l++) begin
            cin = 0;
            for (int j = 0; j < PROD_W; j++) begin
                e     = h[j] + cin - dadda_target(l);
                hp[j] = h[j];
                fa[j] = (e > 0) ? e / 2 : 0;
                ha[j] = (e > 0) ? e % 2 : 0;
                h[j]  = h[j] - 2 * fa[j] - ha[j] + cin;
                cin   = fa[j] + ha[j];
            end
        end
        case (kind)
            0:       return hp[col];
            1:       return fa[col];
            default: return ha[col];
        endcase
    endfunction

    function automatic logic maj3(logic [2:0] v);
        return (v[0] & v[1]) | (v[2] & (v[0] ^ v[1]));
    endfunction

    localparam int NUM_LVL = dadda_levels();

    operand_t        pp [OP_W];                    // row i is a gated by b[i].
    logic [OP_W-1:0] lvl_bits [NUM_LVL+1][PROD_W]; // bits per column, per level.

    for (genvar i = 0; i < OP_W; i++) begin : g_pp
        assign pp[i] = operands.b[i] ? operands.a : '0;
    end

    for (genvar j = 0; j < PROD_W; j++) begin : g_col0
        for (genvar r = 0; r < OP_W; r++) begin : g_row
            if (r < pp_height(j)) begin : g_term
                localparam int IA = (j < OP_W) ? r : j - OP_W + 1 + r;
                assign lvl_bits[0][j][r] = pp[j - IA][IA];
            end else begin : g_pad
                assign lvl_bits[0][j][r] = 1'b0;
            end
        end
    end

    // next level holds kept bits, then sums, then carries from column j-1.
    for (genvar l = 0; l < NUM_LVL; l++) begin : g_lvl
        for (genvar j = 0; j < PROD_W; j++) begin : g_col
            localparam int H    = tree_info(l, j, 0);
            localparam int NFA  = tree_info(l, j, 1);
            localparam int NHA  = tree_info(l, j, 2);
            localparam int PFA  = tree_info(l, j - 1, 1);
            localparam int PHA  = tree_info(l, j - 1, 2);
            localparam int USED = 3 * NFA + 2 * NHA;
            localparam int KEEP = H - USED;
            localparam int NOUT = KEEP + NFA + NHA;
            for (genvar r = 0; r < OP_W; r++) begin : g_slot
                if (r < KEEP) begin : g_pass
                    assign lvl_bits[l+1][j][r] = lvl_bits[l][j][USED + r];
                end else if (r < KEEP + NFA) begin : g_fa_sum
                    assign lvl_bits[l+1][j][r] = ^lvl_bits[l][j][3 * (r - KEEP) +: 3];
                end else if (r < NOUT) begin : g_ha_sum
                    assign lvl_bits[l+1][j][r] =
                        ^lvl_bits[l][j][3 * NFA + 2 * (r - KEEP - NFA) +: 2];
                end else if (r < NOUT + PFA) begin : g_fa_carry
                    assign lvl_bits[l+1][j][r] = maj3(lvl_bits[l][j-1][3 * (r - NOUT) +: 3]);
                end else if (r < NOUT + PFA + PHA) begin : g_ha_carry
                    assign lvl_bits[l+1][j][r] =
                        &lvl_bits[l][j-1][3 * PFA + 2 * (r - NOUT - PFA) +: 2];
                end else begin : g_pad
                    assign lvl_bits[l+1][j][r] = 1'b0;
                end
            end
        end
    end

    // at most two bits left per column.
    always_comb begin
        for (int j = 0; j < PROD_W; j++) begin
            rows.sum_row[j]   = lvl_bits[NUM_LVL][j][0];
            rows.carry_row[j] = lvl_bits[NUM_LVL][j][1];
        end
    end

endmodule

//--- source/mult16_pipe.sv
`timescale 1ns/100ps
`include "mult_consts.svh"

// product comes out `MULT_PIPE_DEPTH cycles after in_valid.
module mult16_pipe (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  mult_data_pkg::operand_t a,
    input  mult_data_pkg::operand_t b,
    output logic                    out_valid,
    output mult_data_pkg::product_t product
);
    import mult_data_pkg::*;
    import mult_pipe_pkg::*;

    op_stage_t  op_q;
    row_stage_t row_q;
    row_pair_t  rows_d;
    product_t   sum_d;

    // operand register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_q <= '0;
        end else begin
            op_q.valid <= in_valid;
            if (in_valid) begin
                op_q.operands <= '{a: a, b: b};
            end
        end
    end

    dadda_tree dadda_tree_inst (
        .operands (op_q.operands),
        .rows     (rows_d)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_q <= '0;
        end else begin
            row_q.valid <= op_q.valid;
            if (op_q.valid) begin
                row_q.rows <= rows_d; // two rows left.
            end
        end
    end

    carry_select_adder carry_select_adder_inst (
        .rows (row_q.rows),
        .sum  (sum_d)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            product   <= '0;
        end else begin
            out_valid <= row_q.valid;
            if (row_q.valid) begin
                product <= sum_d; // held until the next valid result.
            end
        end
    end

endmodule

//--- source/mult_data_pkg.sv
`include "mult_consts.svh"

package mult_data_pkg;

    typedef logic [`MULT_OP_W-1:0] operand_t;

    typedef logic [`MULT_PROD_W-1:0] product_t;

    // both factors of one multiply.
    typedef struct packed {
        operand_t a;
        operand_t b;
    } operands_t;

    // sum_row plus carry_row gives the product.
    typedef struct packed {
        product_t sum_row;
        product_t carry_row;
    } row_pair_t;

endpackage

//--- source/mult_pipe_pkg.sv
`include "mult_consts.svh"

package mult_pipe_pkg;

    typedef struct packed {
        logic                    valid;
        mult_data_pkg::operands_t operands;
    } op_stage_t;

    // rows waiting for the final adder.
    typedef struct packed {
        logic                    valid;
        mult_data_pkg::row_pair_t rows;
    } row_stage_t;

endpackage

//--- verif/mult16_assert.sv
`timescale 1ns/100ps
`include "mult_consts.svh"

module mult16_assert (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    in_valid,
    input logic                    out_valid,
    input mult_data_pkg::product_t product
);

    // valid walks through the three stage registers.
    a_valid_delay : assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, `MULT_PIPE_DEPTH)
    ) else $error("out_valid does not follow in_valid by the pipeline depth");

    a_product_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown(product)
    ) else $error("product has unknown bits while out_valid is high");

    // nothing can be in flight right after reset.
    a_idle_after_reset : assert property (
        @(posedge clk)
        $rose(arst_n) |-> !out_valid
    ) else $error("out_valid is high in the first cycle after reset");

endmodule

//--- verif/mult16_cases.txt
// columns: valid flag, operand a, operand b, expected product, all in hex.
// a line with valid 0 is a bubble, its operands and product are ignored.
1 0000 0000 00000000
1 0000 FFFF 00000000
1 1234 0000 00000000
1 0001 ABCD 0000ABCD
1 BEEF 0001 0000BEEF
0 DEAD BEEF 00000000
1 0001 FFFF 0000FFFF
1 FFFF FFFF FFFE0001
1 0001 0001 00000001
1 0001 0002 00000002
1 0002 0002 00000004
1 0002 0004 00000008
1 0004 0004 00000010
1 0004 0008 00000020
1 0008 0008 00000040
1 0008 0010 00000080
1 0010 0010 00000100
1 0010 0020 00000200
1 0020 0020 00000400
1 0020 0040 00000800
1 0040 0040 00001000
1 0040 0080 00002000
1 0080 0080 00004000
1 0080 0100 00008000
1 0100 0100 00010000
1 0100 0200 00020000
1 0200 0200 00040000
1 0200 0400 00080000
1 0400 0400 00100000
1 0400 0800 00200000
1 0800 0800 00400000
1 0800 1000 00800000
1 1000 1000 01000000
1 1000 2000 02000000
1 2000 2000 04000000
1 2000 4000 08000000
1 4000 4000 10000000
1 4000 8000 20000000
1 8000 8000 40000000
0 FFFF FFFF 00000000
0 1234 5678 00000000
1 5555 5555 1C718E39
1 AAAA AAAA 71C638E4
0 0000 0000 00000000
1 5555 AAAA 38E31C72
1 AAAA FFFF AAA95556

//--- verif/mult16_tb.sv
`timescale 1ns/100ps
`include "mult_consts.svh"

module mult16_tb;
    import mult_data_pkg::*;

    localparam int DEPTH     = `MULT_PIPE_DEPTH;
    localparam int MAX_CASES = 64;
    localparam int NUM_RAND  = 200;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     in_valid;
    operand_t op_a;
    operand_t op_b;
    logic     out_valid;
    product_t product;

    logic [31:0]      case_words [4*MAX_CASES]; // valid, a, b, product per case.
    product_t         exp_q [$];
    logic [DEPTH-1:0] vld_hist;                 // in_valid at the last rising edges.
    logic [15:0]      lfsr;
    int               num_cases;
    int               cycle_limit;
    int               cycle_cnt = 0;
    int               chk_errs  = 0;
    int               out_cnt   = 0;
    int               stim_errs;
    int               in_cnt;
    int               test_cnt;
    int               test_fail;

    mult16_pipe mult16_pipe_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (op_a),
        .b         (op_b),
        .out_valid (out_valid),
        .product   (product)
    );

    bind mult16_pipe mult16_assert mult16_assert_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .product   (product)
    );

    always #20 clk = ~clk;

    function automatic product_t ref_product(input operand_t x, input operand_t y);
        return product_t'(x) * product_t'(y);
    endfunction

    // galois form with taps 16 14 13 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic lfsr_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic drive_op(input logic v, input operand_t x, input operand_t y,
                            input product_t exp_p);
        in_valid = v;
        op_a     = x;
        op_b     = y;
        if (v) begin
            exp_q.push_back(exp_p);
            in_cnt++;
        end
    endtask

    task automatic check_idle(input string when_txt);
        assert (out_valid === 1'b0) else begin
            $display("[ERROR] %0t out_valid %s: got %b, expected 0", $time, when_txt, out_valid);
            stim_errs++;
        end
        assert (product === '0) else begin
            $display("[ERROR] %0t product %s: got %h, expected 0", $time, when_txt, product);
            stim_errs++;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        errs = stim_errs + chk_errs - errs_before;
        test_cnt++;
        if (errs != 0) begin
            test_fail++;
        end
        $display("test %-12s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_hist <= '0;
        end else begin
            vld_hist <= {vld_hist[DEPTH-2:0], in_valid};
        end
    end

    // outputs are sampled half a cycle after they change.
    always @(negedge clk) begin
        product_t exp_p;
        if (arst_n) begin
            assert (out_valid === vld_hist[DEPTH-1]) else begin
                $display("[ERROR] %0t out_valid: got %b, expected %b",
                         $time, out_valid, vld_hist[DEPTH-1]);
                chk_errs++;
            end
            if (out_valid) begin
                out_cnt++;
                assert (exp_q.size() > 0) else begin
                    $display("%0t: a result came out with no operation in flight", $time);
                    chk_errs++;
                end
                if (exp_q.size() > 0) begin
                    exp_p = exp_q.pop_front();
                    assert (product === exp_p) else begin
                        $display("[ERROR] %0t product: got %h, expected %h",
                                 $time, product, exp_p);
                        chk_errs++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        product_t    file_p;
        operand_t    ca;
        operand_t    cb;
        int          errs_start;

        arst_n    = 1'b0;
        in_valid  = 1'b0;
        op_a      = '0;
        op_b      = '0;
        lfsr      = 16'd3415;
        stim_errs = 0;
        in_cnt    = 0;
        test_cnt  = 0;
        test_fail = 0;
        for (int i = 0; i < 4 * MAX_CASES; i++) begin
            case_words[i] = '1; // all ones never appears as a valid flag.
        end
        $readmemh("verif/mult16_cases.txt", case_words);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_words[4*num_cases] <= 32'd1) begin
            num_cases++;
        end
        cycle_limit = num_cases + NUM_RAND + DEPTH + 20;
        assert (num_cases > 0) else begin
            $display("no cases were read from verif/mult16_cases.txt");
            stim_errs++;
        end

        errs_start = 0;
        repeat (3) begin
            @(negedge clk);
            check_idle("during reset");
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        end_test("reset", errs_start);

        errs_start = stim_errs + chk_errs;
        for (int i = 0; i < num_cases; i++) begin
            ca     = case_words[4*i+1][15:0];
            cb     = case_words[4*i+2][15:0];
            file_p = case_words[4*i+3];
            if (case_words[4*i][0]) begin
                assert (file_p === ref_product(ca, cb)) else begin
                    $display("[ERROR] %0t case %0d file product: got %h, expected %h",
                             $time, i, file_p, ref_product(ca, cb));
                    stim_errs++;
                end
            end
            drive_op(case_words[4*i][0], ca, cb, file_p);
            @(negedge clk);
        end
        drive_op(1'b0, '0, '0, '0);
        wait_drain();
        end_test("file cases", errs_start);

        errs_start = stim_errs + chk_errs;
        for (int i = 0; i < NUM_RAND; i++) begin
            lfsr_bits(16, rnd);
            ca = rnd[15:0];
            lfsr_bits(16, rnd);
            cb = rnd[15:0];
            lfsr_bits(1, rnd);
            drive_op(rnd[0], ca, cb, ref_product(ca, cb));
            @(negedge clk);
        end
        drive_op(1'b0, '0, '0, '0);
        wait_drain();
        repeat (DEPTH + 1) @(negedge clk); // no stray out_valid after the last one.
        end_test("random", errs_start);

        errs_start = stim_errs + chk_errs;
        assert (out_cnt == in_cnt) else begin
            $display("%0d results came out for %0d valid inputs", out_cnt, in_cnt);
            stim_errs++;
        end
        end_test("pulse count", errs_start);

        $display("%0d tests, %0d failed, %0d errors, %0d results checked",
                 test_cnt, test_fail, stim_errs + chk_errs, out_cnt);
        if (stim_errs + chk_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
